/* Makefile */
TOP = tb_lmk04906_loader
OBJ = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) \
		--Mdir $(OBJ) -o $(TOP)

run: build
	./$(OBJ)/$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)
	verilator --lint-only -Wall -f src.f --top-module lmk04906_loader

clean:
	rm -rf $(OBJ) sim.log

/* src.f */
+incdir+src
src/uwire_pkg.sv
src/uwire_frame_if.sv
src/load_sequencer.sv
src/uwire_shifter.sv
src/lmk04906_loader.sv
test/uwire_monitor.sv
test/tb_lmk04906_loader.sv

/* src/lmk04906_loader.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LMK04906 uWire loader
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lmk04906_loader (
	input  logic clk_in,
	input  logic reset,
	input  logic start,         // Pulse to send the whole table
	output logic uwire_data,
	output logic uwire_le,
	output logic uwire_clk,
	output logic config_done    // High after the last word
);
	uwire_frame_if frame_bus ();   // One frame in flight

	load_sequencer load_sequencer_inst (
		.clk_in      (clk_in),
		.reset       (reset),
		.start       (start),
		.frame       (frame_bus.seq),
		.config_done (config_done)
	);

	uwire_shifter uwire_shifter_inst (
		.clk_in     (clk_in),
		.reset      (reset),
		.frame      (frame_bus.shift),
		.uwire_data (uwire_data),
		.uwire_le   (uwire_le),
		.uwire_clk  (uwire_clk)
	);
endmodule

`default_nettype wire

/* src/load_sequencer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configuration table sequencer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "uwire_params.svh"

module load_sequencer (
	input  logic       clk_in,
	input  logic       reset,
	input  logic       start,        // One-shot load request
	uwire_frame_if.seq frame,
	output logic       config_done   // Whole table sent
);
	import uwire_pkg::*;

	seq_state_t state;
	cfg_index_t index;          // Current table entry
	cfg_data_t  word;
	cfg_addr_t  word_addr;
	logic       div_reg;        // Address falls in R0..R5
	logic       div_low_big;    // Divide field [10:0] too large
	logic       div_high_big;   // Divide field [22:13] too large
	logic       last_word;

	assign word      = cfg_table[index];
	assign word_addr = cfg_addr_table[index];

	// Large dividers need a second latch pulse on the chip
	assign div_reg      = (word_addr <= `DIV_ADDR_MAX);
	assign div_low_big  = (word[10:0] > `DIV_LOW_LIMIT);
	assign div_high_big = (word[22:13] > `DIV_HIGH_LIMIT);

	assign frame.valid = (state == SEQ_REQUEST);   // Shifter is idle whenever we ask
	assign frame.data  = word;
	assign frame.addr  = word_addr;
	assign frame.ext   = div_reg & (div_low_big | div_high_big);

	assign last_word = (index == cfg_index_t'(`CFG_WORDS - 1));

	always_ff @(posedge clk_in or negedge reset) begin
		if (!reset) begin
			state       <= SEQ_IDLE;
			index       <= '0;
			config_done <= 1'b0;
		end else begin
			case (state)
				SEQ_IDLE, SEQ_FINISHED: begin
					if (start) begin                  // Restart from word 0
						index       <= '0;
						config_done <= 1'b0;
						state       <= SEQ_REQUEST;
					end
				end
				SEQ_REQUEST: begin
					state <= SEQ_WAIT_DONE;           // Frame taken this cycle
				end
				SEQ_WAIT_DONE: begin
					if (frame.done) begin
						if (last_word) begin
							state       <= SEQ_FINISHED;
							config_done <= 1'b1;      // Held until next start
						end else begin
							index <= index + 1'b1;
							state <= SEQ_REQUEST;
						end
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end
endmodule

`default_nettype wire

/* src/uwire_frame_if.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame request bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

interface uwire_frame_if;
	import uwire_pkg::*;

	logic      valid;   // Frame request, one word at a time
	cfg_data_t data;    // Data field, MSB goes out first
	cfg_addr_t addr;    // Register address, sent after data
	logic      ext;     // Divider word, extra latch pulse needed
	logic      done;    // One cycle, frame plus gap finished

	modport seq (
		output valid,
		output data,
		output addr,
		output ext,
		input  done
	);

	modport shift (
		input  valid,
		input  data,
		input  addr,
		input  ext,
		output done
	);
endinterface

`default_nettype wire

/* src/uwire_params.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uWire loader sizes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef UWIRE_PARAMS_SVH
`define UWIRE_PARAMS_SVH

`define UWIRE_DATA_W          27   // Data bits per frame, MSB first
`define UWIRE_ADDR_W          5    // Register address bits after the data
`define UWIRE_FRAME_W         32   // Data plus address
`define UWIRE_CNT_W           6    // Bit-cycle and gap counter

`define UWIRE_FRAME_CYCLES    64   // LE low window, two clk_in cycles per bit
`define UWIRE_GAP_CYCLES      19   // LE high between ordinary frames
`define UWIRE_EXT_GAP_CYCLES  16   // LE high after the extra latch pulse
`define UWIRE_EXT_START       3    // Gap cycle where the extra pulse begins
`define UWIRE_EXT_CYCLES      6    // Extra LE low pulse, three uWire clocks

`define CFG_WORDS             26   // Entries in the configuration table
`define CFG_INDEX_W           5    // Table position width

`define DIV_ADDR_MAX          5    // R0..R5 hold the clock divider words
`define DIV_LOW_LIMIT         25   // Divide field [10:0] threshold
`define DIV_HIGH_LIMIT        12   // Divide field [22:13] threshold

`endif

/* src/uwire_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uWire loader types and table
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "uwire_params.svh"

package uwire_pkg;
	typedef logic [`UWIRE_DATA_W-1:0] cfg_data_t;    // Frame data field
	typedef logic [`UWIRE_ADDR_W-1:0] cfg_addr_t;    // Chip register number
	typedef logic [`CFG_INDEX_W-1:0]  cfg_index_t;   // Position in the table

	typedef enum logic [1:0] {SEQ_IDLE, SEQ_REQUEST, SEQ_WAIT_DONE, SEQ_FINISHED} seq_state_t;
	typedef enum logic [1:0] {SH_IDLE, SH_SHIFT, SH_GAP, SH_EXTRA} shift_state_t;

	// Chip setup, single PLL with 0-delay, sent in this order
	localparam cfg_data_t cfg_table [`CFG_WORDS] = '{
		27'b0000_0000_0000_0010_0000_0000_000,   // R0 soft reset
		27'b0000_0000_0000_0000_0000_1010_000,   // R0 clk0 divide 80
		27'b0000_0000_0000_0000_0111_1101_000,   // R1 clk1 divide 1000
		27'b0000_0000_0000_0000_0000_0101_000,   // R2 clk2 divide 40
		27'b1000_0000_0000_0000_0000_0011_001,   // R3 clk3 off
		27'b1000_0000_0000_0000_0000_0011_001,   // R4 clk4 off
		27'b1000_0000_0000_0000_0000_0011_001,   // R5 clk5 off
		27'b0000_0001_0001_0000_0000_0000_000,   // R6 output types
		27'b0000_0000_0001_0000_0000_0000_000,   // R7
		27'b0000_0000_0000_0000_0000_0000_000,   // R8
		27'b0101_0101_0101_0101_0101_0101_010,   // R9 fixed pattern
		27'b0001_0001_0101_0010_0100_0010_000,   // R10 OSCout setup
		27'b0011_0111_1111_0001_0001_0000_000,   // R11 mode and SYNC
		27'b0001_0011_0000_1100_0000_0000_011,   // R12 LD pin, holdover
		27'b0011_1011_0000_0010_0000_0110_000,   // R13 holdover pin, clkin
		27'b0001_0010_0000_0000_0000_0000_000,   // R14
		27'b1000_0000_0000_0000_1000_0000_000,   // R15 holdover exit
		27'b0000_0001_0101_0101_0000_0100_000,   // R16 fixed pattern
		27'b0000_0000_0000_0000_0000_0000_110,   // R24 PLL2 loop filter
		27'b0000_0001_0000_0001_0000_0000_000,   // R25 DAC, PLL1 unused
		27'b0010_1111_1010_1000_0000_0000_000,   // R26 PLL2 charge pump
		27'b0001_0000_0000_0000_0001_1000_000,   // R27 PLL1 R, unused
		27'b0000_0000_0010_0000_0011_0000_000,   // R28 PLL2 R
		27'b0000_0000_1000_0000_0000_0011_000,   // R29 PLL2 N cal
		27'b0000_0010_0000_0000_0000_0011_000,   // R30 PLL2 N and P
		27'b0000_0000_0001_1111_0000_0000_000    // R31 uWire lock off
	};

	// R0 goes twice, the register map skips R17..R23
	localparam cfg_addr_t cfg_addr_table [`CFG_WORDS] = '{
		5'd0,  5'd0,  5'd1,  5'd2,  5'd3,  5'd4,  5'd5,
		5'd6,  5'd7,  5'd8,  5'd9,  5'd10, 5'd11, 5'd12,
		5'd13, 5'd14, 5'd15, 5'd16,
		5'd24, 5'd25, 5'd26, 5'd27, 5'd28, 5'd29, 5'd30, 5'd31
	};
endpackage

`default_nettype wire

/* src/uwire_shifter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uWire frame serializer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "uwire_params.svh"

module uwire_shifter (
	input  logic         clk_in,
	input  logic         reset,
	uwire_frame_if.shift frame,
	output logic         uwire_data,
	output logic         uwire_le,     // Chip latches the word on rise
	output logic         uwire_clk     // Chip samples data on rise
);
	import uwire_pkg::*;

	typedef logic [`UWIRE_CNT_W-1:0] cnt_t;

	localparam cnt_t FRAME_LAST   = cnt_t'(`UWIRE_FRAME_CYCLES - 1);
	localparam cnt_t GAP_LAST     = cnt_t'(`UWIRE_GAP_CYCLES - 1);
	localparam cnt_t EXT_GAP_LAST = cnt_t'(`UWIRE_EXT_GAP_CYCLES - 1);
	localparam cnt_t EXT_AT       = cnt_t'(`UWIRE_EXT_START - 1);
	localparam cnt_t EXT_LAST     = cnt_t'(`UWIRE_EXT_CYCLES - 1);

	shift_state_t             state;
	cnt_t                     cnt;         // Cycle of the value now on the pins
	logic [`UWIRE_FRAME_W-2:0] shreg;      // Frame bits after the MSB
	logic                     ext_pend;    // Extra pulse still owed
	logic                     after_ext;   // Use the shorter gap
	logic                     gap_end;

	assign gap_end = after_ext ? (cnt == EXT_GAP_LAST) : (cnt == GAP_LAST);

	always_ff @(posedge clk_in) begin
		if (state == SH_IDLE && frame.valid) begin
			shreg <= {frame.data[`UWIRE_DATA_W-2:0], frame.addr};
		end else if (state == SH_SHIFT && cnt[0]) begin
			shreg <= {shreg[`UWIRE_FRAME_W-3:0], 1'b0};   // Next bit after clk high
		end
	end

	always_ff @(posedge clk_in or negedge reset) begin
		if (!reset) begin
			state      <= SH_IDLE;
			cnt        <= '0;
			ext_pend   <= 1'b0;
			after_ext  <= 1'b0;
			uwire_le   <= 1'b1;
			uwire_clk  <= 1'b0;
			uwire_data <= 1'b0;
			frame.done <= 1'b0;
		end else begin
			frame.done <= 1'b0;
			case (state)
				SH_IDLE: begin
					if (frame.valid) begin
						state      <= SH_SHIFT;
						cnt        <= '0;
						ext_pend   <= frame.ext;
						after_ext  <= 1'b0;
						uwire_le   <= 1'b0;                   // Frame window opens
						uwire_clk  <= 1'b0;
						uwire_data <= frame.data[`UWIRE_DATA_W-1];
					end
				end
				SH_SHIFT: begin
					if (cnt == FRAME_LAST) begin
						state      <= SH_GAP;
						cnt        <= '0;
						uwire_le   <= 1'b1;                   // Latch the word
						uwire_clk  <= 1'b0;
						uwire_data <= 1'b0;
					end else begin
						cnt       <= cnt + 1'b1;
						uwire_clk <= ~cnt[0];                 // High on odd cycles
						if (cnt[0]) begin
							uwire_data <= shreg[`UWIRE_FRAME_W-2];
						end
					end
				end
				SH_GAP: begin
					if (ext_pend && cnt == EXT_AT) begin
						state    <= SH_EXTRA;
						cnt      <= '0;
						ext_pend <= 1'b0;
						uwire_le <= 1'b0;                     // Second latch pulse
					end else if (gap_end) begin
						state      <= SH_IDLE;
						frame.done <= 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				SH_EXTRA: begin
					if (cnt == EXT_LAST) begin
						state     <= SH_GAP;
						cnt       <= '0;
						after_ext <= 1'b1;
						uwire_le  <= 1'b1;
						uwire_clk <= 1'b0;
					end else begin
						cnt       <= cnt + 1'b1;
						uwire_clk <= ~cnt[0];                 // Three clock pulses
					end
				end
				default: begin
					state <= SH_IDLE;
				end
			endcase
		end
	end
endmodule

`default_nettype wire

/* test/tb_lmk04906_loader.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LMK04906 loader testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_lmk04906_loader;
	localparam int LOADS        = 4;
	localparam int LOAD_TIMEOUT = 6000;   // Cycles, one table takes about 2300

	logic clk_in;
	logic reset;
	logic start;
	logic uwire_data;
	logic uwire_le;
	logic uwire_clk;
	logic config_done;
	logic timed_out;
	int   load;
	int   t;
	int   checks;
	int   errors;

	lmk04906_loader lmk04906_loader_inst (
		.clk_in      (clk_in),
		.reset       (reset),
		.start       (start),
		.uwire_data  (uwire_data),
		.uwire_le    (uwire_le),
		.uwire_clk   (uwire_clk),
		.config_done (config_done)
	);

	uwire_monitor uwire_monitor_inst (
		.clk_in      (clk_in),
		.reset       (reset),
		.uwire_data  (uwire_data),
		.uwire_le    (uwire_le),
		.uwire_clk   (uwire_clk),
		.config_done (config_done)
	);

	initial begin
		clk_in = 1'b0;
		forever #10 clk_in = ~clk_in;   // 20 ns period
	end

	function automatic string test_name(input int n);
		case (n)
			1:       return "frame content";
			2:       return "frame shape";
			3:       return "extra latch pulse";
			4:       return "start handling";
			default: return "reset";
		endcase
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk_in);
	endtask

	// One start pulse, then wait for config_done, maybe poking start meanwhile
	task automatic load_table(input logic extra_starts);
		int cycle;
		start = 1'b1;
		@(negedge clk_in);
		start = 1'b0;
		for (cycle = 0; cycle < LOAD_TIMEOUT && !config_done; cycle++) begin
			@(negedge clk_in);
			start = extra_starts && ($urandom_range(0, 99) < 3);   // Ignored while loading
		end
		start = 1'b0;
		if (!config_done) begin
			timed_out = 1'b1;
			$display("Timeout: config_done did not rise within %0d cycles", LOAD_TIMEOUT);
		end
	endtask

	// Start a load and cut it off with a reset between clock edges
	task automatic abort_with_reset();
		start = 1'b1;
		@(negedge clk_in);
		start = 1'b0;
		idle_cycles($urandom_range(50, 1500));
		#($urandom_range(1, 9));
		reset = 1'b0;
		idle_cycles($urandom_range(2, 6));
		reset = 1'b1;
	endtask

	initial begin
		void'($urandom(6217));
		reset     = 1'b0;
		start     = 1'b0;
		timed_out = 1'b0;
		repeat (16) @(posedge clk_in);
		@(negedge clk_in);
		reset = 1'b1;
		for (load = 0; load < LOADS && !timed_out; load++) begin
			idle_cycles($urandom_range(1, 200));
			if (load == 1) begin
				abort_with_reset();
				idle_cycles($urandom_range(1, 200));
			end
			load_table(load != 0);
		end
		idle_cycles(40);   // Let the last gap drain
		checks = 0;
		errors = 0;
		for (t = 1; t <= 5; t++) begin
			checks += uwire_monitor_inst.test_checks[t];
			errors += uwire_monitor_inst.test_errs[t];
			if (uwire_monitor_inst.test_checks[t] == 0) begin
				errors++;
				$display("Test %0d %s: never exercised", t, test_name(t));
			end else begin
				$display("Test %0d %s: %0d checks, %0d errors", t, test_name(t),
					uwire_monitor_inst.test_checks[t], uwire_monitor_inst.test_errs[t]);
			end
		end
		$display("Tests 5, checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end
endmodule

`default_nettype wire

/* test/uwire_monitor.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uWire pin checker
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "uwire_params.svh"

module uwire_monitor (
	input wire logic clk_in,
	input wire logic reset,
	input wire logic uwire_data,
	input wire logic uwire_le,
	input wire logic uwire_clk,
	input wire logic config_done
);
	import uwire_pkg::*;

	int          test_checks [1:5] = '{default: 0};   // Read by the testbench top
	int          test_errs [1:5]   = '{default: 0};
	logic        prev_le     = 1'b1;
	logic        prev_clk    = 1'b0;
	logic        prev_done   = 1'b0;
	int          low_cnt     = 0;      // LE low samples in this window
	int          high_cnt    = 0;      // LE high samples since the last window
	int          rises       = 0;      // uWire clock rising edges in this window
	int          exp_idx     = 0;      // Next table entry expected
	logic        ext_owed    = 1'b0;   // Last frame was a divider word
	logic        after_reset = 1'b0;
	logic [31:0] bits        = '0;     // Frame rebuilt from sampled data

	// Large divide values on R0..R5 need the second latch pulse
	function automatic logic is_divider(input int idx);
		cfg_data_t w;
		w = cfg_table[idx];
		return (cfg_addr_table[idx] <= `DIV_ADDR_MAX) &&
			((w[10:0] > `DIV_LOW_LIMIT) || (w[22:13] > `DIV_HIGH_LIMIT));
	endfunction

	task automatic check_value(input int t, input string name, input logic [63:0] got,
			input logic [63:0] exp);
		test_checks[t]++;
		if (got !== exp) begin
			test_errs[t]++;
			$display("[FAIL] %0t ns: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_true(input int t, input logic ok, input string what);
		test_checks[t]++;
		if (!ok) begin
			test_errs[t]++;
			$display("At %0t ns: %s", $time, what);
		end
	endtask

	// Called on every LE rise, classifies the window that just closed
	task automatic close_window();
		logic [31:0] exp_bits;
		if (low_cnt == `UWIRE_EXT_CYCLES) begin                  // Short window, extra pulse
			check_true(3, ext_owed && high_cnt == `UWIRE_EXT_START && rises == 3,
				"extra latch pulse appeared where none was due, or was misshaped");
			ext_owed = 1'b0;
		end else begin
			check_true(3, !ext_owed, "extra latch pulse missing after a divider word");
			ext_owed = 1'b0;
			check_value(2, "uwire_le low cycles", 64'(low_cnt), 64'(`UWIRE_FRAME_CYCLES));
			check_value(2, "uwire_clk rising edges", 64'(rises), 64'(`UWIRE_FRAME_W));
			test_checks[2]++;
			if (exp_idx > 0 && high_cnt < `UWIRE_EXT_GAP_CYCLES) begin   // First frame has no gap
				test_errs[2]++;
				$display("[FAIL] %0t ns: uwire_le gap got %0d expected at least %0d",
					$time, high_cnt, `UWIRE_EXT_GAP_CYCLES);
			end
			if (exp_idx < `CFG_WORDS) begin
				exp_bits = {cfg_table[exp_idx], cfg_addr_table[exp_idx]};
				check_value(1, $sformatf("uwire frame %0d", exp_idx), 64'(bits), 64'(exp_bits));
				ext_owed = is_divider(exp_idx);
				exp_idx++;
			end else begin
				check_true(4, 1'b0, "a frame was sent after the whole table was loaded");
			end
		end
	endtask

	// Pins change after the rising edge, so look at them on the falling one
	always @(negedge clk_in) begin
		if (!reset) begin
			check_value(5, "uwire_le", 64'(uwire_le), 64'd1);
			check_value(5, "uwire_clk", 64'(uwire_clk), 64'd0);
			check_value(5, "uwire_data", 64'(uwire_data), 64'd0);
			check_value(5, "config_done", 64'(config_done), 64'd0);
			exp_idx     = 0;                                     // Partial load is dropped
			ext_owed    = 1'b0;
			low_cnt     = 0;
			high_cnt    = 0;
			rises       = 0;
			after_reset = 1'b1;
			prev_le     = 1'b1;
			prev_clk    = 1'b0;
			prev_done   = 1'b0;
		end else begin
			if (config_done && !prev_done) begin                  // Load finished
				check_value(4, "config_done frames sent", 64'(exp_idx), 64'(`CFG_WORDS));
				check_true(3, !ext_owed, "extra latch pulse missing after the last word");
				if (after_reset) begin
					check_value(5, "frames after reset", 64'(exp_idx), 64'(`CFG_WORDS));
					after_reset = 1'b0;
				end
			end
			if (!config_done && prev_done) begin
				exp_idx = 0;                                         // New load from word 0
			end
			if (!uwire_le) begin
				if (prev_le) begin
					low_cnt = 0;
					rises   = 0;
				end
				low_cnt++;
				if (uwire_clk && !prev_clk) begin                    // Chip samples here
					rises++;
					bits = {bits[30:0], uwire_data};
				end
			end else begin
				if (!prev_le) begin
					close_window();
					high_cnt = 0;
				end
				high_cnt++;
			end
			prev_le   = uwire_le;
			prev_clk  = uwire_clk;
			prev_done = config_done;
		end
	end
endmodule

`default_nettype wire
